// ==== src/pcyn_types_pkg.sv ====
// data, tag and memory address widths with their vector types.
// CDB lane count and reservation station sizes.

package pcyn_types_pkg;

    // ********************
    // widths
    // ********************

    localparam int DATA_WIDTH     = 32;
    localparam int TAG_WIDTH      = 5;
    localparam int MEM_ADDR_WIDTH = 4;

    // ********************
    // sizes
    // ********************

    // lane 0 carries ALU results, lane 1 carries LSU results.
    localparam int CDB_DEPTH = 2;

    localparam int ALU_RS_DEPTH = 4;
    localparam int LSU_RS_DEPTH = 4;

    // ********************
    // vector types
    // ********************

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

endpackage

// ==== src/pcyn_isa_pkg.sv ====
// opcode encoding for the issue slice.
// masks that classify each opcode as ALU or LSU work.

package pcyn_isa_pkg;

    localparam int OPCODE_WIDTH = 3;
    localparam int OPCODE_COUNT = 2 ** OPCODE_WIDTH;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_LOAD  = 3'd5,
        OP_STORE = 3'd6
    } opcode_t;

    // ********************
    // station classification
    // ********************

    // one bit per opcode value, set when that opcode belongs to the station.
    // code 7 is unused and falls in neither mask.
    localparam logic [OPCODE_COUNT-1:0] ALU_OPCODE_MASK = (OPCODE_COUNT'(1) << OP_ADD) |
                                                          (OPCODE_COUNT'(1) << OP_SUB) |
                                                          (OPCODE_COUNT'(1) << OP_AND) |
                                                          (OPCODE_COUNT'(1) << OP_OR)  |
                                                          (OPCODE_COUNT'(1) << OP_XOR);

    localparam logic [OPCODE_COUNT-1:0] LSU_OPCODE_MASK = (OPCODE_COUNT'(1) << OP_LOAD) |
                                                          (OPCODE_COUNT'(1) << OP_STORE);

endpackage

// ==== src/rs_switch.sv ====
// enqueue router between the ALU and LSU reservation stations.
// also captures CDB data for sources broadcast in the enqueue cycle.

`timescale 1ns/1ps

module rs_switch (
    input  logic                  i_cdb_en      [0:pcyn_types_pkg::CDB_DEPTH-1],
    input  pcyn_types_pkg::data_t i_cdb_data    [0:pcyn_types_pkg::CDB_DEPTH-1],
    input  pcyn_types_pkg::tag_t  i_cdb_tag     [0:pcyn_types_pkg::CDB_DEPTH-1],

    input  logic                  i_rs_en,
    input  pcyn_isa_pkg::opcode_t i_rs_opcode,
    input  pcyn_types_pkg::tag_t  i_rs_src_tag  [0:1],
    input  pcyn_types_pkg::data_t i_rs_src_data [0:1],
    input  logic                  i_rs_src_rdy  [0:1],
    output logic                  o_rs_en       [0:1],
    output pcyn_types_pkg::tag_t  o_rs_src_tag  [0:1],
    output pcyn_types_pkg::data_t o_rs_src_data [0:1],
    output logic                  o_rs_src_rdy  [0:1],

    input  logic                  i_rs_stall    [0:1],
    output logic                  o_rs_stall
);

    import pcyn_types_pkg::*;
    import pcyn_isa_pkg::*;

    logic rs_opcode_is_alu;
    logic rs_opcode_is_lsu;
    logic cdb_src_hit [0:1][0:CDB_DEPTH-1];

    // station 0 is the ALU station, station 1 the LSU station.
    assign rs_opcode_is_alu = ALU_OPCODE_MASK[i_rs_opcode];
    assign rs_opcode_is_lsu = LSU_OPCODE_MASK[i_rs_opcode];

    assign o_rs_en[0] = i_rs_en & rs_opcode_is_alu;
    assign o_rs_en[1] = i_rs_en & rs_opcode_is_lsu;

    // the station itself refuses the enqueue when full.
    assign o_rs_stall = rs_opcode_is_lsu ? i_rs_stall[1] : i_rs_stall[0];

    // ********************
    // CDB bypass
    // ********************

    // only sources still waiting look at the bus.
    always_comb begin
        for (int src_idx = 0; src_idx < 2; src_idx++) begin
            for (int cdb_idx = 0; cdb_idx < CDB_DEPTH; cdb_idx++) begin
                cdb_src_hit[src_idx][cdb_idx] = ~i_rs_src_rdy[src_idx] & i_cdb_en[cdb_idx] &
                                                (i_cdb_tag[cdb_idx] == i_rs_src_tag[src_idx]);
            end
        end
    end

    always_comb begin
        for (int src_idx = 0; src_idx < 2; src_idx++) begin
            o_rs_src_tag[src_idx]  = i_rs_src_tag[src_idx];
            o_rs_src_data[src_idx] = i_rs_src_data[src_idx];
            o_rs_src_rdy[src_idx]  = i_rs_src_rdy[src_idx];

            for (int cdb_idx = 0; cdb_idx < CDB_DEPTH; cdb_idx++) begin
                if (cdb_src_hit[src_idx][cdb_idx]) begin
                    o_rs_src_data[src_idx] = i_cdb_data[cdb_idx];
                    o_rs_src_rdy[src_idx]  = 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/reservation_station.sv ====
// reservation station entry array with CDB wakeup.
// issues the oldest ready entry, or only the oldest entry when IN_ORDER is set.

`timescale 1ns/1ps

module reservation_station #(
    parameter int DEPTH    = 4,
    parameter bit IN_ORDER = 1'b0
)(
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_cdb_en       [0:pcyn_types_pkg::CDB_DEPTH-1],
    input  pcyn_types_pkg::data_t i_cdb_data     [0:pcyn_types_pkg::CDB_DEPTH-1],
    input  pcyn_types_pkg::tag_t  i_cdb_tag      [0:pcyn_types_pkg::CDB_DEPTH-1],

    input  logic                  i_enq_en,
    input  pcyn_isa_pkg::opcode_t i_enq_opcode,
    input  pcyn_types_pkg::tag_t  i_enq_dst_tag,
    input  pcyn_types_pkg::tag_t  i_enq_src_tag  [0:1],
    input  pcyn_types_pkg::data_t i_enq_src_data [0:1],
    input  logic                  i_enq_src_rdy  [0:1],
    output logic                  o_stall,

    output logic                  o_issue_en,
    output pcyn_isa_pkg::opcode_t o_issue_opcode,
    output pcyn_types_pkg::tag_t  o_issue_dst_tag,
    output pcyn_types_pkg::data_t o_issue_src_data [0:1]
);

    import pcyn_types_pkg::*;
    import pcyn_isa_pkg::*;

    localparam int IDX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [IDX_WIDTH-1:0] idx_t;
    typedef enum logic [1:0] {EMPTY, WAITING, READY} entry_state_t;

    entry_state_t entry_state    [0:DEPTH-1];
    idx_t         entry_age      [0:DEPTH-1];
    logic         entry_src_rdy  [0:DEPTH-1][0:1];
    opcode_t      entry_opcode   [0:DEPTH-1];
    tag_t         entry_dst_tag  [0:DEPTH-1];
    tag_t         entry_src_tag  [0:DEPTH-1][0:1];
    data_t        entry_src_data [0:DEPTH-1][0:1];

    logic               wake_en   [0:DEPTH-1][0:1];
    data_t              wake_data [0:DEPTH-1][0:1];
    logic [IDX_WIDTH:0] occ_count;
    logic               enq_accept;
    idx_t               enq_idx;
    idx_t               enq_age;
    logic               sel_en;
    idx_t               sel_idx;
    idx_t               sel_age;

    // ********************
    // occupancy
    // ********************

    // ages stay compact: 0 is the oldest occupied entry.
    // the lowest empty slot takes the next enqueue.
    always_comb begin
        occ_count = '0;
        enq_idx   = '0;
        o_stall   = 1'b1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (entry_state[i] == EMPTY) begin
                o_stall = 1'b0;
                enq_idx = idx_t'(i);
            end else begin
                occ_count = occ_count + 1'b1;
            end
        end
    end

    assign enq_accept = i_enq_en & ~o_stall;
    assign enq_age    = idx_t'(occ_count - (IDX_WIDTH + 1)'(sel_en));

    // ********************
    // wakeup and select
    // ********************

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                wake_en[i][s]   = 1'b0;
                wake_data[i][s] = entry_src_data[i][s];
                for (int c = 0; c < CDB_DEPTH; c++) begin
                    if ((entry_state[i] == WAITING) && !entry_src_rdy[i][s] && i_cdb_en[c] &&
                        (i_cdb_tag[c] == entry_src_tag[i][s])) begin
                        wake_en[i][s]   = 1'b1;
                        wake_data[i][s] = i_cdb_data[c];
                    end
                end
            end
        end
    end

    // in-order mode only ever considers the age 0 entry.
    always_comb begin
        sel_en  = 1'b0;
        sel_idx = '0;
        sel_age = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if ((entry_state[i] == READY) && (!IN_ORDER || (entry_age[i] == '0)) &&
                (!sel_en || (entry_age[i] < sel_age))) begin
                sel_en  = 1'b1;
                sel_idx = idx_t'(i);
                sel_age = entry_age[i];
            end
        end
    end

    // ********************
    // entry update
    // ********************

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry_state[i]      <= EMPTY;
                entry_age[i]        <= '0;
                entry_src_rdy[i][0] <= 1'b0;
                entry_src_rdy[i][1] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (enq_accept && (enq_idx == idx_t'(i))) begin
                    entry_state[i] <= (i_enq_src_rdy[0] && i_enq_src_rdy[1]) ? READY : WAITING;
                    entry_age[i]   <= enq_age;
                    for (int s = 0; s < 2; s++) begin
                        entry_src_rdy[i][s] <= i_enq_src_rdy[s];
                    end
                end else if (sel_en && (sel_idx == idx_t'(i))) begin
                    entry_state[i] <= EMPTY;
                end else if (entry_state[i] != EMPTY) begin
                    if (sel_en && (entry_age[i] > sel_age)) begin
                        entry_age[i] <= entry_age[i] - 1'b1;
                    end
                    for (int s = 0; s < 2; s++) begin
                        entry_src_rdy[i][s] <= entry_src_rdy[i][s] | wake_en[i][s];
                    end
                    if ((entry_src_rdy[i][0] | wake_en[i][0]) &&
                        (entry_src_rdy[i][1] | wake_en[i][1])) begin
                        entry_state[i] <= READY;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (enq_accept && (enq_idx == idx_t'(i))) begin
                entry_opcode[i]  <= i_enq_opcode;
                entry_dst_tag[i] <= i_enq_dst_tag;
                for (int s = 0; s < 2; s++) begin
                    entry_src_tag[i][s]  <= i_enq_src_tag[s];
                    entry_src_data[i][s] <= i_enq_src_data[s];
                end
            end else begin
                for (int s = 0; s < 2; s++) begin
                    entry_src_data[i][s] <= wake_data[i][s];
                end
            end
        end
    end

    // ********************
    // issue register
    // ********************

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_issue_en <= 1'b0;
        end else begin
            o_issue_en <= sel_en;
        end
    end

    always_ff @(posedge clk) begin
        o_issue_opcode      <= entry_opcode[sel_idx];
        o_issue_dst_tag     <= entry_dst_tag[sel_idx];
        o_issue_src_data[0] <= entry_src_data[sel_idx][0];
        o_issue_src_data[1] <= entry_src_data[sel_idx][1];
    end

endmodule

// ==== src/alu_unit.sv ====
// single cycle integer unit.
// drives CDB lane 0.

`timescale 1ns/1ps

module alu_unit (
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_issue_en,
    input  pcyn_isa_pkg::opcode_t i_opcode,
    input  pcyn_types_pkg::tag_t  i_dst_tag,
    input  pcyn_types_pkg::data_t i_src_data [0:1],

    output logic                  o_cdb_en,
    output pcyn_types_pkg::data_t o_cdb_data,
    output pcyn_types_pkg::tag_t  o_cdb_tag
);

    import pcyn_types_pkg::*;
    import pcyn_isa_pkg::*;

    data_t alu_result;

    // subtraction takes source 0 minus source 1.
    always_comb begin
        case (i_opcode)
            OP_ADD:  alu_result = i_src_data[0] + i_src_data[1];
            OP_SUB:  alu_result = i_src_data[0] - i_src_data[1];
            OP_AND:  alu_result = i_src_data[0] & i_src_data[1];
            OP_OR:   alu_result = i_src_data[0] | i_src_data[1];
            OP_XOR:  alu_result = i_src_data[0] ^ i_src_data[1];
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_issue_en;
        end
    end

    always_ff @(posedge clk) begin
        o_cdb_data <= alu_result;
        o_cdb_tag  <= i_dst_tag;
    end

endmodule

// ==== src/lsu_unit.sv ====
// single cycle load/store unit with a small word addressed data memory.
// drives CDB lane 1.

`timescale 1ns/1ps

module lsu_unit (
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_issue_en,
    input  pcyn_isa_pkg::opcode_t i_opcode,
    input  pcyn_types_pkg::tag_t  i_dst_tag,
    input  pcyn_types_pkg::data_t i_src_data [0:1],

    output logic                  o_cdb_en,
    output pcyn_types_pkg::data_t o_cdb_data,
    output pcyn_types_pkg::tag_t  o_cdb_tag
);

    import pcyn_types_pkg::*;
    import pcyn_isa_pkg::*;

    localparam int MEM_WORDS = 2 ** MEM_ADDR_WIDTH;

    data_t     mem [0:MEM_WORDS-1];
    mem_addr_t mem_addr;
    logic      is_store;

    // only the low address bits of source 0 select a word.
    assign mem_addr = i_src_data[0][MEM_ADDR_WIDTH-1:0];
    assign is_store = (i_opcode == OP_STORE);

    always_ff @(posedge clk) begin
        if (i_issue_en && is_store) begin
            mem[mem_addr] <= i_src_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_issue_en;
        end
    end

    // a store broadcasts the word it wrote so that its tag completes.
    always_ff @(posedge clk) begin
        o_cdb_data <= is_store ? i_src_data[1] : mem[mem_addr];
        o_cdb_tag  <= i_dst_tag;
    end

endmodule

// ==== src/dispatch_core.sv ====
// issue slice top level.
// switch, ALU and LSU stations, execution units and the two lane CDB.

`timescale 1ns/1ps

module dispatch_core (
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_rs_en,
    input  pcyn_isa_pkg::opcode_t i_rs_opcode,
    input  pcyn_types_pkg::tag_t  i_rs_dst_tag,
    input  pcyn_types_pkg::tag_t  i_rs_src_tag  [0:1],
    input  pcyn_types_pkg::data_t i_rs_src_data [0:1],
    input  logic                  i_rs_src_rdy  [0:1],
    output logic                  o_rs_stall,

    output logic                  o_cdb_en      [0:pcyn_types_pkg::CDB_DEPTH-1],
    output pcyn_types_pkg::data_t o_cdb_data    [0:pcyn_types_pkg::CDB_DEPTH-1],
    output pcyn_types_pkg::tag_t  o_cdb_tag     [0:pcyn_types_pkg::CDB_DEPTH-1]
);

    import pcyn_types_pkg::*;
    import pcyn_isa_pkg::*;

    // ********************
    // CDB
    // ********************

    logic  cdb_en   [0:CDB_DEPTH-1];
    data_t cdb_data [0:CDB_DEPTH-1];
    tag_t  cdb_tag  [0:CDB_DEPTH-1];

    assign o_cdb_en   = cdb_en;
    assign o_cdb_data = cdb_data;
    assign o_cdb_tag  = cdb_tag;

    logic    rs_en       [0:1];
    logic    rs_stall    [0:1];
    tag_t    rs_src_tag  [0:1];
    data_t   rs_src_data [0:1];
    logic    rs_src_rdy  [0:1];

    logic    alu_issue_en;
    opcode_t alu_issue_opcode;
    tag_t    alu_issue_dst_tag;
    data_t   alu_issue_src_data [0:1];
    logic    lsu_issue_en;
    opcode_t lsu_issue_opcode;
    tag_t    lsu_issue_dst_tag;
    data_t   lsu_issue_src_data [0:1];

    rs_switch rs_switch_i (
        .i_cdb_en(cdb_en), .i_cdb_data(cdb_data), .i_cdb_tag(cdb_tag),
        .i_rs_en(i_rs_en), .i_rs_opcode(i_rs_opcode),
        .i_rs_src_tag(i_rs_src_tag), .i_rs_src_data(i_rs_src_data),
        .i_rs_src_rdy(i_rs_src_rdy),
        .o_rs_en(rs_en), .o_rs_src_tag(rs_src_tag), .o_rs_src_data(rs_src_data),
        .o_rs_src_rdy(rs_src_rdy),
        .i_rs_stall(rs_stall), .o_rs_stall(o_rs_stall)
    );

    reservation_station #(.DEPTH(ALU_RS_DEPTH), .IN_ORDER(1'b0)) alu_rs (
        .clk(clk), .i_reset(i_reset),
        .i_cdb_en(cdb_en), .i_cdb_data(cdb_data), .i_cdb_tag(cdb_tag),
        .i_enq_en(rs_en[0]), .i_enq_opcode(i_rs_opcode), .i_enq_dst_tag(i_rs_dst_tag),
        .i_enq_src_tag(rs_src_tag), .i_enq_src_data(rs_src_data),
        .i_enq_src_rdy(rs_src_rdy), .o_stall(rs_stall[0]),
        .o_issue_en(alu_issue_en), .o_issue_opcode(alu_issue_opcode),
        .o_issue_dst_tag(alu_issue_dst_tag), .o_issue_src_data(alu_issue_src_data)
    );

    // memory operations issue in program order.
    reservation_station #(.DEPTH(LSU_RS_DEPTH), .IN_ORDER(1'b1)) lsu_rs (
        .clk(clk), .i_reset(i_reset),
        .i_cdb_en(cdb_en), .i_cdb_data(cdb_data), .i_cdb_tag(cdb_tag),
        .i_enq_en(rs_en[1]), .i_enq_opcode(i_rs_opcode), .i_enq_dst_tag(i_rs_dst_tag),
        .i_enq_src_tag(rs_src_tag), .i_enq_src_data(rs_src_data),
        .i_enq_src_rdy(rs_src_rdy), .o_stall(rs_stall[1]),
        .o_issue_en(lsu_issue_en), .o_issue_opcode(lsu_issue_opcode),
        .o_issue_dst_tag(lsu_issue_dst_tag), .o_issue_src_data(lsu_issue_src_data)
    );

    alu_unit alu_unit_i (
        .clk(clk), .i_reset(i_reset),
        .i_issue_en(alu_issue_en), .i_opcode(alu_issue_opcode),
        .i_dst_tag(alu_issue_dst_tag), .i_src_data(alu_issue_src_data),
        .o_cdb_en(cdb_en[0]), .o_cdb_data(cdb_data[0]), .o_cdb_tag(cdb_tag[0])
    );

    lsu_unit lsu_unit_i (
        .clk(clk), .i_reset(i_reset),
        .i_issue_en(lsu_issue_en), .i_opcode(lsu_issue_opcode),
        .i_dst_tag(lsu_issue_dst_tag), .i_src_data(lsu_issue_src_data),
        .o_cdb_en(cdb_en[1]), .o_cdb_data(cdb_data[1]), .o_cdb_tag(cdb_tag[1])
    );

endmodule

// ==== testbench/dispatch_core_chk.sv ====
// checker bound to the issue slice top level.
// concurrent assertions on the CDB lanes.

`timescale 1ns/1ps

module dispatch_core_chk (
    input logic                 clk,
    input logic                 i_reset,
    input logic                 i_cdb_en  [0:pcyn_types_pkg::CDB_DEPTH-1],
    input pcyn_types_pkg::tag_t i_cdb_tag [0:pcyn_types_pkg::CDB_DEPTH-1]
);

    import pcyn_types_pkg::*;

    int fail_count = 0;

    // both units clear their broadcast on every reset edge.
    cdb_quiet_in_reset_a: assert property (@(posedge clk)
        i_reset |=> !i_cdb_en[0] && !i_cdb_en[1]
    ) else begin
        $error("CDB enable high during reset or in the cycle after it");
        fail_count++;
    end

    for (genvar lane = 0; lane < CDB_DEPTH; lane++) begin : g_lane
        cdb_tag_known_a: assert property (@(posedge clk) disable iff (i_reset)
            i_cdb_en[lane] |-> !$isunknown(i_cdb_tag[lane])
        ) else begin
            $error("CDB lane %0d broadcast an unknown tag", lane);
            fail_count++;
        end
    end

    cdb_tags_distinct_a: assert property (@(posedge clk) disable iff (i_reset)
        (i_cdb_en[0] && i_cdb_en[1]) |-> (i_cdb_tag[0] != i_cdb_tag[1])
    ) else begin
        $error("both CDB lanes carried the same tag in one cycle");
        fail_count++;
    end

endmodule

bind dispatch_core dispatch_core_chk dispatch_core_chk_i (
    .clk(clk), .i_reset(i_reset), .i_cdb_en(o_cdb_en), .i_cdb_tag(o_cdb_tag)
);

// ==== testbench/dispatch_core_tb.sv ====
// testbench for the issue slice top level.
// drives instruction groups, keeps an expected value per tag and counts errors.

`timescale 1ns/1ps

module dispatch_core_tb;

    import pcyn_types_pkg::*;
    import pcyn_isa_pkg::*;

    localparam int TAG_COUNT = 2 ** TAG_WIDTH;
    localparam int MEM_WORDS = 2 ** MEM_ADDR_WIDTH;

    logic    clk = 1'b0;
    logic    i_reset;
    logic    i_rs_en;
    opcode_t i_rs_opcode;
    tag_t    i_rs_dst_tag;
    tag_t    i_rs_src_tag  [0:1];
    data_t   i_rs_src_data [0:1];
    logic    i_rs_src_rdy  [0:1];
    logic    o_rs_stall;
    logic    o_cdb_en      [0:CDB_DEPTH-1];
    data_t   o_cdb_data    [0:CDB_DEPTH-1];
    tag_t    o_cdb_tag     [0:CDB_DEPTH-1];

    // bookkeeping per destination tag.
    data_t exp_val    [0:TAG_COUNT-1];
    bit    issued     [0:TAG_COUNT-1];
    bit    seen       [0:TAG_COUNT-1];
    bit    is_mem     [0:TAG_COUNT-1];
    int    enq_cycle  [0:TAG_COUNT-1];
    int    seen_cycle [0:TAG_COUNT-1];
    data_t mem_model  [0:MEM_WORDS-1];
    tag_t  lsu_order  [$];

    int   seed = 35;
    int   cycle;
    int   pending;
    int   num_issued;
    int   assert_errors;
    int   compare_errors;
    tag_t next_tag;
    tag_t last_tag;
    tag_t chain_tag;
    bit   stall_seen;
    bit   dual_seen;

    always #4 clk = ~clk;

    dispatch_core dispatch_core_i (
        .clk(clk), .i_reset(i_reset),
        .i_rs_en(i_rs_en), .i_rs_opcode(i_rs_opcode), .i_rs_dst_tag(i_rs_dst_tag),
        .i_rs_src_tag(i_rs_src_tag), .i_rs_src_data(i_rs_src_data),
        .i_rs_src_rdy(i_rs_src_rdy), .o_rs_stall(o_rs_stall),
        .o_cdb_en(o_cdb_en), .o_cdb_data(o_cdb_data), .o_cdb_tag(o_cdb_tag)
    );

    // the run ends here when broadcasts stop arriving.
    initial begin
        wait (cycle > 40 * num_issued + 100);
        $display("timeout after %0d cycles with %0d tags never broadcast", cycle, pending);
        $display("Simulation failed");
        $finish;
    end

    // ********************
    // CDB monitor
    // ********************

    function automatic data_t random_word(input logic [3:0] low);
        data_t w;
        w = $random(seed);
        return {w[DATA_WIDTH-1:4], low};
    endfunction

    // a tag broadcast in the current cycle still counts as pending.
    function automatic bit tag_available(input tag_t t);
        return seen[t] && (seen_cycle[t] != cycle);
    endfunction

    task automatic sample_cdb();
        tag_t t;
        for (int lane = 0; lane < CDB_DEPTH; lane++) begin
            if (o_cdb_en[lane] === 1'b1) begin
                t = o_cdb_tag[lane];
                assert (issued[t] && !seen[t]) else begin
                    $display("tag %0d on lane %0d was broadcast twice or never enqueued", t, lane);
                    assert_errors++;
                end
                if (issued[t] && !seen[t]) begin
                    seen[t]       = 1'b1;
                    seen_cycle[t] = cycle;
                    pending--;
                    assert (o_cdb_data[lane] === exp_val[t]) else begin
                        $display("MISMATCH o_cdb_data[%0d] tag %0d expected %h actual %h",
                                 lane, t, exp_val[t], o_cdb_data[lane]);
                        compare_errors++;
                    end
                    // three falling edges after driving is two cycles after acceptance.
                    assert (cycle - enq_cycle[t] >= 3) else begin
                        $display("tag %0d broadcast less than 2 cycles after acceptance", t);
                        assert_errors++;
                    end
                    if (lane == 0) begin
                        assert (!is_mem[t]) else begin
                            $display("memory tag %0d broadcast on the ALU lane", t);
                            assert_errors++;
                        end
                    end else begin
                        assert (lsu_order.size() > 0 && lsu_order[0] == t) else begin
                            $display("memory tag %0d completed out of program order", t);
                            assert_errors++;
                        end
                        if (lsu_order.size() > 0) begin
                            lsu_order.delete(0);
                        end
                    end
                end
            end
        end
        if (o_cdb_en[0] === 1'b1 && o_cdb_en[1] === 1'b1) begin
            dual_seen = 1'b1;
        end
    endtask

    task automatic step();
        @(negedge clk);
        cycle++;
        sample_cdb();
    endtask

    task automatic drain();
        while (pending > 0) begin
            step();
        end
    endtask

    // ********************
    // enqueue
    // ********************

    // a source marked dep names the tag in its low bits, else it is the value.
    task automatic send(input opcode_t op, input bit dep0, input data_t v0,
                        input bit dep1, input data_t v1);
        bit    dep  [0:1];
        data_t val  [0:1];
        data_t opnd [0:1];
        tag_t  t;
        dep[0] = dep0;
        dep[1] = dep1;
        val[0] = v0;
        val[1] = v1;
        t = next_tag;
        next_tag++;
        for (int s = 0; s < 2; s++) begin
            opnd[s]          = dep[s] ? exp_val[tag_t'(val[s])] : val[s];
            i_rs_src_tag[s]  = dep[s] ? tag_t'(val[s]) : '0;
            i_rs_src_rdy[s]  = !dep[s] || tag_available(tag_t'(val[s]));
            i_rs_src_data[s] = i_rs_src_rdy[s] ? opnd[s] : '0;
        end
        i_rs_en      = 1'b1;
        i_rs_opcode  = op;
        i_rs_dst_tag = t;
        case (op)
            OP_ADD:  exp_val[t] = opnd[0] + opnd[1];
            OP_SUB:  exp_val[t] = opnd[0] - opnd[1];
            OP_AND:  exp_val[t] = opnd[0] & opnd[1];
            OP_OR:   exp_val[t] = opnd[0] | opnd[1];
            OP_XOR:  exp_val[t] = opnd[0] ^ opnd[1];
            OP_LOAD: exp_val[t] = mem_model[opnd[0][MEM_ADDR_WIDTH-1:0]];
            default: begin
                mem_model[opnd[0][MEM_ADDR_WIDTH-1:0]] = opnd[1];
                exp_val[t] = opnd[1];
            end
        endcase
        is_mem[t] = (op == OP_LOAD) || (op == OP_STORE);
        if (is_mem[t]) begin
            lsu_order.push_back(t);
        end
        issued[t] = 1'b1;
        pending++;
        num_issued++;
        last_tag = t;
        // stall follows the opcode combinationally.
        #1;
        while (o_rs_stall) begin
            stall_seen = 1'b1;
            step();
            #1;
        end
        enq_cycle[t] = cycle;
        step();
        i_rs_en = 1'b0;
    endtask

    // ********************
    // stimulus
    // ********************

    initial begin
        i_reset      = 1'b1;
        i_rs_en      = 1'b0;
        i_rs_opcode  = OP_ADD;
        i_rs_dst_tag = '0;
        for (int s = 0; s < 2; s++) begin
            i_rs_src_tag[s]  = '0;
            i_rs_src_data[s] = '0;
            i_rs_src_rdy[s]  = 1'b0;
        end
        next_tag = '0;
        repeat (4) step();
        i_reset = 1'b0;

        // independent ALU operations.
        send(OP_ADD, 1'b0, $random(seed), 1'b0, $random(seed));
        send(OP_SUB, 1'b0, $random(seed), 1'b0, $random(seed));
        send(OP_AND, 1'b0, $random(seed), 1'b0, $random(seed));
        send(OP_OR,  1'b0, $random(seed), 1'b0, $random(seed));
        send(OP_XOR, 1'b0, $random(seed), 1'b0, $random(seed));
        drain();

        // dependent operation woken from the CDB.
        send(OP_ADD, 1'b0, $random(seed), 1'b0, $random(seed));
        send(OP_SUB, 1'b1, last_tag, 1'b0, $random(seed));
        drain();

        // the consumer arrives in the producer's broadcast cycle.
        send(OP_XOR, 1'b0, $random(seed), 1'b0, $random(seed));
        step();
        step();
        send(OP_ADD, 1'b1, last_tag, 1'b0, $random(seed));
        drain();

        // stores then a load of the first address.
        // the low nibbles chain the loads of the next group.
        send(OP_STORE, 1'b0, 32'h2, 1'b0, random_word(4'h7));
        send(OP_STORE, 1'b0, 32'h7, 1'b0, random_word(4'hb));
        send(OP_STORE, 1'b0, 32'hb, 1'b0, $random(seed));
        send(OP_LOAD,  1'b0, 32'h2, 1'b0, 32'h0);
        drain();

        // a slow load chain keeps five ALU operations waiting.
        send(OP_LOAD, 1'b0, 32'h2, 1'b0, 32'h0);
        send(OP_LOAD, 1'b1, last_tag, 1'b0, 32'h0);
        send(OP_LOAD, 1'b1, last_tag, 1'b0, 32'h0);
        chain_tag = last_tag;
        repeat (4) send(OP_ADD, 1'b1, chain_tag, 1'b0, $random(seed));
        send(OP_SUB, 1'b1, last_tag, 1'b0, $random(seed));
        drain();

        // mixed burst so that both lanes broadcast together.
        // the waiting store holds back the younger ready load.
        send(OP_ADD, 1'b0, $random(seed), 1'b0, $random(seed));
        chain_tag = last_tag;
        send(OP_STORE, 1'b0, 32'h5, 1'b1, chain_tag);
        send(OP_LOAD,  1'b0, 32'h7, 1'b0, 32'h0);
        send(OP_OR,    1'b1, chain_tag, 1'b0, $random(seed));
        send(OP_XOR,   1'b1, chain_tag, 1'b0, $random(seed));
        drain();
        repeat (10) step();

        assert (stall_seen) else begin
            $display("o_rs_stall never rose while the ALU station was full");
            assert_errors++;
        end
        assert (dual_seen) else begin
            $display("no cycle carried broadcasts on both CDB lanes");
            assert_errors++;
        end
        assert_errors += dispatch_core_i.dispatch_core_chk_i.fail_count;
        $display("errors: %0d assertion, %0d compare", assert_errors, compare_errors);
        if (assert_errors == 0 && compare_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/pcyn_types_pkg.sv
src/pcyn_isa_pkg.sv
src/rs_switch.sv
src/reservation_station.sv
src/alu_unit.sv
src/lsu_unit.sv
src/dispatch_core.sv
testbench/dispatch_core_chk.sv
testbench/dispatch_core_tb.sv

// ==== Bender.yml ====
package:
  name: dispatch_core

sources:
  - target: any(rtl, test)
    files:
      - src/pcyn_types_pkg.sv
      - src/pcyn_isa_pkg.sv
      - src/rs_switch.sv
      - src/reservation_station.sv
      - src/alu_unit.sv
      - src/lsu_unit.sv
      - src/dispatch_core.sv

  - target: test
    files:
      - testbench/dispatch_core_chk.sv
      - testbench/dispatch_core_tb.sv
